//--- hdl/axi_dwn_pkg.sv
`default_nettype none

package axi_dwn_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int unsigned ADDR_WIDTH        = 32;
  localparam int unsigned ID_WIDTH          = 4;
  localparam int unsigned WIDE_DATA_WIDTH   = 64;
  localparam int unsigned NARROW_DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [ID_WIDTH-1:0]   id_t;
  typedef logic [7:0]            len_t;
  typedef logic [2:0]            size_t;
  typedef logic [1:0]            burst_t;
  typedef logic [3:0]            cache_t;
  typedef logic [1:0]            resp_t;

  // Up to 256 narrow beats per burst
  typedef logic [8:0]            beat_cnt_t;

  localparam burst_t BURST_INCR       = 2'b01;
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  // ----------------------------------------
  // Channel and descriptor structs
  // ----------------------------------------
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } aw_req_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_resp_t;

  typedef struct packed {
    addr_t     addr;
    size_t     size;      // Size of the wide request
    beat_cnt_t beats;     // Narrow beats still to send
    logic      downsize;
  } burst_desc_t;

  // Clear the address bits below the given transfer size
  function automatic addr_t align_addr(addr_t addr, size_t size);
    return addr & ~((addr_t'(1) << size) - addr_t'(1));
  endfunction

endpackage

`default_nettype wire

//--- hdl/aw_downsize_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module aw_downsize_decoder import axi_dwn_pkg::*; #(
  parameter int unsigned WIDE_DATA_WIDTH   = axi_dwn_pkg::WIDE_DATA_WIDTH,
  parameter int unsigned NARROW_DATA_WIDTH = axi_dwn_pkg::NARROW_DATA_WIDTH
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  aw_req_t     slv_aw_i,
  input  logic        slv_aw_valid_i,
  output logic        slv_aw_ready_o,

  output aw_req_t     mst_aw_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,

  output burst_desc_t desc_o,
  output logic        desc_valid_o,
  input  logic        burst_done_i
);

  localparam int unsigned N_OFF       = $clog2(NARROW_DATA_WIDTH / 8);
  localparam int unsigned W_OFF       = $clog2(WIDE_DATA_WIDTH / 8);
  localparam size_t       NARROW_SIZE = size_t'(N_OFF);

  typedef enum logic [1:0] {
    IDLE,
    ISSUING,
    ACTIVE
  } state_e;

  state_e      state_q, state_d;
  aw_req_t     aw_q;
  burst_desc_t desc_q;

  logic             aw_fire;
  logic             do_downsize;
  logic [W_OFF-1:0] size_mask;
  logic [W_OFF-1:0] align_adj;
  logic [15:0]      beats_full;
  beat_cnt_t        narrow_beats;

  // ----------------------------------------
  // Request decode
  // ----------------------------------------
  assign aw_fire     = slv_aw_valid_i & slv_aw_ready_o;
  assign do_downsize = ((slv_aw_i.cache & CACHE_MODIFIABLE) != '0) &&
                       (slv_aw_i.burst == BURST_INCR) &&
                       (slv_aw_i.size > NARROW_SIZE);

  // Narrow words skipped at the start of an unaligned first beat
  assign size_mask  = ~({W_OFF{1'b1}} << slv_aw_i.size);
  assign align_adj  = (slv_aw_i.addr[W_OFF-1:0] & size_mask) >> N_OFF;
  assign beats_full = ((16'(slv_aw_i.len) + 16'd1) << (slv_aw_i.size - NARROW_SIZE)) -
                      16'(align_adj);

  assign narrow_beats = do_downsize ? beats_full[8:0] :
                        beat_cnt_t'(slv_aw_i.len) + beat_cnt_t'(1);

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (aw_fire) state_d = ISSUING;
      ISSUING: if (mst_aw_ready_i) state_d = ACTIVE;
      ACTIVE:  if (burst_done_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the re-encoded request
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      aw_q            <= slv_aw_i;
      desc_q.addr     <= slv_aw_i.addr;
      desc_q.size     <= slv_aw_i.size;
      desc_q.beats    <= narrow_beats;
      desc_q.downsize <= do_downsize;
      if (do_downsize) begin
        aw_q.size <= NARROW_SIZE;
        aw_q.len  <= len_t'(beats_full - 16'd1);
      end
    end
  end

  assign slv_aw_ready_o = (state_q == IDLE);
  assign mst_aw_valid_o = (state_q == ISSUING);
  assign mst_aw_o       = aw_q;
  assign desc_o         = desc_q;
  assign desc_valid_o   = (state_q == ACTIVE);

  // Longer bursts would need splitting on the narrow side
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_fire && do_downsize |-> slv_aw_i.len <= len_t'(127))
    else $error("Downsized burst longer than 128 wide beats");

  // Serializer lane steering only covers beats up to the narrow width
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_fire && !do_downsize |-> slv_aw_i.size <= NARROW_SIZE)
    else $error("Pass-through request wider than the narrow bus");

endmodule

`default_nettype wire

//--- hdl/w_word_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module w_word_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  payload_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,

  output payload_t word_o,
  output logic     word_valid_o,
  input  logic     pop_i
);

  payload_t entry_q;
  logic     full_q;
  logic     load;

  // Free slot, or the current one leaves this cycle
  assign in_ready_o = ~full_q | pop_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (pop_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      entry_q <= in_i;
    end
  end

  assign word_o       = entry_q;
  assign word_valid_o = full_q;

  // The consumer only pops a word it has seen
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> full_q)
    else $error("Pop from an empty word buffer");

endmodule

`default_nettype wire

//--- hdl/w_beat_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module w_beat_serializer import axi_dwn_pkg::*; #(
  parameter int unsigned WIDE_DATA_WIDTH   = axi_dwn_pkg::WIDE_DATA_WIDTH,
  parameter int unsigned NARROW_DATA_WIDTH = axi_dwn_pkg::NARROW_DATA_WIDTH
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  input  burst_desc_t                    desc_i,
  input  logic                           desc_valid_i,
  output logic                           burst_done_o,

  input  logic [WIDE_DATA_WIDTH-1:0]     word_data_i,
  input  logic [WIDE_DATA_WIDTH/8-1:0]   word_strb_i,
  input  logic                           word_last_i,
  input  logic                           word_valid_i,
  output logic                           pop_o,

  output logic [NARROW_DATA_WIDTH-1:0]   mst_w_data_o,
  output logic [NARROW_DATA_WIDTH/8-1:0] mst_w_strb_o,
  output logic                           mst_w_last_o,
  output logic                           mst_w_valid_o,
  input  logic                           mst_w_ready_i
);

  localparam int unsigned N_BYTES     = NARROW_DATA_WIDTH / 8;
  localparam int unsigned N_OFF       = $clog2(N_BYTES);
  localparam int unsigned W_OFF       = $clog2(WIDE_DATA_WIDTH / 8);
  localparam size_t       NARROW_SIZE = size_t'(N_OFF);

  // Byte offset inside a narrow word, one bit wider for the end bound
  typedef logic [N_OFF:0] lane_off_t;

  logic      busy_q;
  addr_t     addr_q;
  beat_cnt_t cnt_q;

  addr_t                  cur_addr;
  addr_t                  next_addr;
  beat_cnt_t              cur_cnt;
  size_t                  beat_size;
  logic [W_OFF-N_OFF-1:0] lane_sel;
  lane_off_t              beat_bytes;
  lane_off_t              lo_off;
  lane_off_t              hi_off;
  logic                   beat_fire;
  logic                   final_beat;
  logic                   crosses;

  // First beat of a burst reads straight from the descriptor
  assign cur_addr  = busy_q ? addr_q : desc_i.addr;
  assign cur_cnt   = busy_q ? cnt_q : desc_i.beats;
  assign beat_size = desc_i.downsize ? NARROW_SIZE : desc_i.size;

  // ----------------------------------------
  // Lane steering
  // ----------------------------------------
  assign lane_sel   = cur_addr[W_OFF-1:N_OFF];
  assign beat_bytes = lane_off_t'(1) << beat_size;
  assign lo_off     = lane_off_t'(cur_addr[N_OFF-1:0]);
  assign hi_off     = (lo_off & ~(beat_bytes - lane_off_t'(1))) + beat_bytes;

  always_comb begin
    mst_w_data_o = '0;
    mst_w_strb_o = '0;
    for (int unsigned j = 0; j < N_BYTES; j++) begin
      // Only the bytes of the current beat, from the address up
      if (j >= 32'(lo_off) && j < 32'(hi_off)) begin
        mst_w_data_o[8*j +: 8] = word_data_i[8*(lane_sel*N_BYTES + j) +: 8];
        mst_w_strb_o[j]        = word_strb_i[lane_sel*N_BYTES + j];
      end
    end
  end

  // ----------------------------------------
  // Beat sequencing
  // ----------------------------------------
  assign mst_w_valid_o = desc_valid_i & word_valid_i;
  assign beat_fire     = mst_w_valid_o & mst_w_ready_i;
  assign final_beat    = (cur_cnt == beat_cnt_t'(1));
  assign mst_w_last_o  = final_beat;

  assign next_addr = align_addr(cur_addr, beat_size) + (addr_t'(1) << beat_size);
  assign crosses   = align_addr(next_addr, desc_i.size) != align_addr(cur_addr, desc_i.size);

  // Wide word is used up at the end of its original-size slot
  assign pop_o        = beat_fire & (final_beat | crosses);
  assign burst_done_o = beat_fire & final_beat;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      addr_q <= '0;
      cnt_q  <= '0;
    end else if (beat_fire) begin
      busy_q <= ~final_beat;
      addr_q <= next_addr;
      cnt_q  <= cur_cnt - beat_cnt_t'(1);
    end
  end

  // Narrow beat count from the decoder ends with the wide last beat
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_fire && final_beat |-> word_last_i)
    else $error("Final narrow beat taken from a wide beat without last");

endmodule

`default_nettype wire

//--- hdl/axi_data_downsize.sv
`timescale 1ns/1ps
`default_nettype none

module axi_data_downsize import axi_dwn_pkg::*; #(
  parameter int unsigned WIDE_DATA_WIDTH   = axi_dwn_pkg::WIDE_DATA_WIDTH,
  parameter int unsigned NARROW_DATA_WIDTH = axi_dwn_pkg::NARROW_DATA_WIDTH
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // Wide slave port
  input  aw_req_t                        slv_aw_i,
  input  logic                           slv_aw_valid_i,
  output logic                           slv_aw_ready_o,
  input  logic [WIDE_DATA_WIDTH-1:0]     slv_w_data_i,
  input  logic [WIDE_DATA_WIDTH/8-1:0]   slv_w_strb_i,
  input  logic                           slv_w_last_i,
  input  logic                           slv_w_valid_i,
  output logic                           slv_w_ready_o,
  output b_resp_t                        slv_b_o,
  output logic                           slv_b_valid_o,
  input  logic                           slv_b_ready_i,

  // Narrow master port
  output aw_req_t                        mst_aw_o,
  output logic                           mst_aw_valid_o,
  input  logic                           mst_aw_ready_i,
  output logic [NARROW_DATA_WIDTH-1:0]   mst_w_data_o,
  output logic [NARROW_DATA_WIDTH/8-1:0] mst_w_strb_o,
  output logic                           mst_w_last_o,
  output logic                           mst_w_valid_o,
  input  logic                           mst_w_ready_i,
  input  b_resp_t                        mst_b_i,
  input  logic                           mst_b_valid_i,
  output logic                           mst_b_ready_o
);

  typedef struct packed {
    logic [WIDE_DATA_WIDTH-1:0]   data;
    logic [WIDE_DATA_WIDTH/8-1:0] strb;
    logic                         last;
  } wide_w_t;

  wide_w_t     slv_w;
  wide_w_t     buf_word;
  logic        buf_valid;
  logic        pop;
  burst_desc_t desc;
  logic        desc_valid;
  logic        burst_done;

  assign slv_w.data = slv_w_data_i;
  assign slv_w.strb = slv_w_strb_i;
  assign slv_w.last = slv_w_last_i;

  aw_downsize_decoder #(
    .WIDE_DATA_WIDTH   (WIDE_DATA_WIDTH),
    .NARROW_DATA_WIDTH (NARROW_DATA_WIDTH)
  ) aw_downsize_decoder_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .desc_o         (desc),
    .desc_valid_o   (desc_valid),
    .burst_done_i   (burst_done)
  );

  w_word_buffer #(
    .payload_t (wide_w_t)
  ) w_word_buffer_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_i         (slv_w),
    .in_valid_i   (slv_w_valid_i),
    .in_ready_o   (slv_w_ready_o),
    .word_o       (buf_word),
    .word_valid_o (buf_valid),
    .pop_i        (pop)
  );

  w_beat_serializer #(
    .WIDE_DATA_WIDTH   (WIDE_DATA_WIDTH),
    .NARROW_DATA_WIDTH (NARROW_DATA_WIDTH)
  ) w_beat_serializer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .desc_i        (desc),
    .desc_valid_i  (desc_valid),
    .burst_done_o  (burst_done),
    .word_data_i   (buf_word.data),
    .word_strb_i   (buf_word.strb),
    .word_last_i   (buf_word.last),
    .word_valid_i  (buf_valid),
    .pop_o         (pop),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_strb_o  (mst_w_strb_o),
    .mst_w_last_o  (mst_w_last_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  // B needs no conversion
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

`default_nettype wire

//--- tb/downsize_model.svh
`ifndef DOWNSIZE_MODEL_SVH
`define DOWNSIZE_MODEL_SVH

// Expected narrow W beat
typedef struct packed {
  logic [31:0] data;
  logic [3:0]  strb;
  logic        last;
} narrow_beat_t;

// Modifiable INCR wider than the narrow bus gets re-sized
function automatic logic downsized(aw_req_t aw);
  return aw.cache[1] && (aw.burst == BURST_INCR) && (aw.size > 3'd2);
endfunction

function automatic int unsigned narrow_count(aw_req_t aw);
  int unsigned skip;
  if (!downsized(aw)) begin
    return 32'(aw.len) + 1;
  end
  // Narrow words below the start address inside the first wide slot
  skip = 32'(aw.addr[2:0] & 3'((1 << aw.size) - 1)) >> 2;
  return ((32'(aw.len) + 1) << (aw.size - 3'd2)) - skip;
endfunction

function automatic aw_req_t model_aw(aw_req_t aw);
  aw_req_t r;
  r = aw;
  if (downsized(aw)) begin
    r.size = 3'd2;
    r.len  = len_t'(narrow_count(aw) - 1);
  end
  return r;
endfunction

// Walk every wide beat and slice it into narrow beats by address
task automatic build_expected(input aw_req_t aw);
  addr_t        a;
  addr_t        blk_end;
  size_t        bs;
  int unsigned  total;
  int unsigned  cnt;
  int unsigned  lo;
  int unsigned  hi;
  int unsigned  nbytes;
  int unsigned  sel;
  narrow_beat_t b;
  bs    = downsized(aw) ? 3'd2 : aw.size;
  total = narrow_count(aw);
  cnt   = 0;
  for (int unsigned k = 0; k <= 32'(aw.len); k++) begin
    a = (k == 0) ? aw.addr : ((aw.addr >> aw.size) << aw.size) + (addr_t'(k) << aw.size);
    blk_end = ((a >> aw.size) << aw.size) + (addr_t'(1) << aw.size);
    do begin
      nbytes = 32'(1) << bs;
      lo     = 32'(a[1:0]);
      hi     = (lo & ~(nbytes - 1)) + nbytes;
      sel    = 32'(a[2]);
      b      = '0;
      for (int unsigned j = 0; j < 4; j++) begin
        if (j >= lo && j < hi) begin
          b.data[8*j +: 8] = wide_data[k][8*(4*sel + j) +: 8];
          b.strb[j]        = wide_strb[k][4*sel + j];
        end
      end
      cnt++;
      b.last = (cnt == total);
      exp_q.push_back(b);
      a = ((a >> bs) << bs) + (addr_t'(1) << bs);
    end while (a < blk_end);
  end
endtask

`endif

//--- tb/tb_axi_data_downsize.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_data_downsize import axi_dwn_pkg::*; ();

  localparam int unsigned NUM_TXN        = 60;
  localparam int unsigned TXN_CYCLES     = 160;
  localparam int unsigned TIMEOUT_CYCLES = NUM_TXN * TXN_CYCLES + 200;

  logic        clk_i;
  logic        rst_ni;
  aw_req_t     slv_aw_i;
  logic        slv_aw_valid_i;
  logic        slv_aw_ready_o;
  logic [63:0] slv_w_data_i;
  logic [7:0]  slv_w_strb_i;
  logic        slv_w_last_i;
  logic        slv_w_valid_i;
  logic        slv_w_ready_o;
  b_resp_t     slv_b_o;
  logic        slv_b_valid_o;
  logic        slv_b_ready_i;
  aw_req_t     mst_aw_o;
  logic        mst_aw_valid_o;
  logic        mst_aw_ready_i;
  logic [31:0] mst_w_data_o;
  logic [3:0]  mst_w_strb_o;
  logic        mst_w_last_o;
  logic        mst_w_valid_o;
  logic        mst_w_ready_i;
  b_resp_t     mst_b_i;
  logic        mst_b_valid_i;
  logic        mst_b_ready_o;

  logic [63:0] wide_data [16];
  logic [7:0]  wide_strb [16];

  `include "downsize_model.svh"

  narrow_beat_t exp_q [$];
  narrow_beat_t exp_beat;
  narrow_beat_t got_beat;
  aw_req_t      exp_aw;
  logic         aw_seen;
  logic [31:0]  stim_lfsr;
  logic [31:0]  rdy_lfsr;
  string        cur_test;
  int unsigned  errors;
  int unsigned  tests_run;
  int unsigned  tests_failed;

  axi_data_downsize #(
    .WIDE_DATA_WIDTH   (64),
    .NARROW_DATA_WIDTH (32)
  ) axi_data_downsize_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Random numbers
  // ----------------------------------------
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] st, input int unsigned n,
                           output logic [31:0] v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      st = lfsr_step(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  // Narrow side ready, high about three cycles in four
  initial begin
    logic [31:0] v;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    wait (rst_ni === 1'b1);
    forever begin
      @(posedge clk_i);
      #1;
      take_bits(rdy_lfsr, 2, v);
      mst_aw_ready_i = (v[1:0] != 2'b00);
      take_bits(rdy_lfsr, 2, v);
      mst_w_ready_i = (v[1:0] != 2'b00);
    end
  end

  // ----------------------------------------
  // Monitors, sampled mid-cycle
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        assert (mst_aw_o == exp_aw) else begin
          $display("Fail %s mst_aw: expected %h, actual %h", cur_test, exp_aw, mst_aw_o);
          errors++;
        end
        aw_seen = 1'b1;
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        assert (aw_seen) else begin
          $display("Error in %s: narrow W beat sent before its AW handshake", cur_test);
          errors++;
        end
        assert (exp_q.size() != 0) else begin
          $display("Error in %s: narrow W beat sent beyond the expected count", cur_test);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_beat = exp_q.pop_front();
          got_beat = {mst_w_data_o, mst_w_strb_o, mst_w_last_o};
          assert (got_beat == exp_beat) else begin
            $display("Fail %s mst_w {data,strb,last}: expected %h, actual %h",
                     cur_test, exp_beat, got_beat);
            errors++;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // One write transaction
  // ----------------------------------------
  task automatic run_txn(input int unsigned t);
    aw_req_t     aw;
    logic [31:0] v;
    logic [31:0] v2;
    logic        fired;
    cur_test = $sformatf("txn_%0d", t);
    take_bits(stim_lfsr, 2, v);
    aw.size = size_t'(v[1:0]);
    take_bits(stim_lfsr, 4, v);
    aw.len = len_t'(v[3:0]);
    take_bits(stim_lfsr, 16, v);
    aw.addr = addr_t'(v[15:0]);
    take_bits(stim_lfsr, 4, v);
    aw.id = id_t'(v[3:0]);
    take_bits(stim_lfsr, 4, v);
    aw.cache = cache_t'(v[3:0]);
    aw.burst = BURST_INCR;
    // A 64-bit beat is only legal here when it can be split
    if (aw.size == 3'd3) begin
      aw.cache = aw.cache | CACHE_MODIFIABLE;
    end
    for (int unsigned k = 0; k <= 32'(aw.len); k++) begin
      take_bits(stim_lfsr, 32, v);
      take_bits(stim_lfsr, 32, v2);
      wide_data[k] = {v, v2};
      take_bits(stim_lfsr, 8, v);
      wide_strb[k] = v[7:0];
    end
    exp_aw  = model_aw(aw);
    aw_seen = 1'b0;
    exp_q.delete();
    build_expected(aw);

    slv_aw_i       = aw;
    slv_aw_valid_i = 1'b1;
    do begin
      @(negedge clk_i);
      fired = slv_aw_ready_o;
      @(posedge clk_i);
      #1;
    end while (!fired);
    slv_aw_valid_i = 1'b0;

    for (int unsigned k = 0; k <= 32'(aw.len); k++) begin
      slv_w_data_i  = wide_data[k];
      slv_w_strb_i  = wide_strb[k];
      slv_w_last_i  = (k == 32'(aw.len));
      slv_w_valid_i = 1'b1;
      do begin
        @(negedge clk_i);
        fired = slv_w_ready_o;
        @(posedge clk_i);
        #1;
      end while (!fired);
      slv_w_valid_i = 1'b0;
    end

    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    #1;

    // B passes straight through in both directions
    take_bits(stim_lfsr, 2, v);
    mst_b_i       = {aw.id, v[1:0]};
    mst_b_valid_i = 1'b1;
    do begin
      take_bits(stim_lfsr, 1, v);
      slv_b_ready_i = v[0];
      @(negedge clk_i);
      assert ({slv_b_valid_o, slv_b_o} == {1'b1, mst_b_i}) else begin
        $display("Fail %s slv_b: expected %h, actual %h", cur_test,
                 {1'b1, mst_b_i}, {slv_b_valid_o, slv_b_o});
        errors++;
      end
      assert (mst_b_ready_o == slv_b_ready_i) else begin
        $display("Fail %s mst_b_ready: expected %b, actual %b", cur_test,
                 slv_b_ready_i, mst_b_ready_o);
        errors++;
      end
      fired = slv_b_ready_i;
      @(posedge clk_i);
      #1;
    end while (!fired);
    mst_b_valid_i = 1'b0;
    slv_b_ready_i = 1'b0;
  endtask

  task automatic report_test(input int unsigned errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL", cur_test);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int unsigned err0;
    stim_lfsr      = 32'h3429_3060;
    rdy_lfsr       = 32'h3429_3060;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    exp_aw         = '0;
    aw_seen        = 1'b0;
    rst_ni         = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    cur_test = "reset_state";
    err0     = errors;
    @(negedge clk_i);
    assert ({mst_aw_valid_o, mst_w_valid_o, slv_aw_ready_o, slv_w_ready_o} == 4'b0011)
      else begin
      $display("Fail %s {aw_v,w_v,aw_rdy,w_rdy}: expected 0011, actual %b", cur_test,
               {mst_aw_valid_o, mst_w_valid_o, slv_aw_ready_o, slv_w_ready_o});
      errors++;
    end
    @(posedge clk_i);
    #1;
    report_test(err0);

    for (int unsigned t = 0; t < NUM_TXN; t++) begin
      err0 = errors;
      run_txn(t);
      report_test(err0);
    end

    $display("Tests run: %0d, failed: %0d, check errors: %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog sized for the longest bursts under back-pressure
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+tb
hdl/axi_dwn_pkg.sv
hdl/aw_downsize_decoder.sv
hdl/w_word_buffer.sv
hdl/w_beat_serializer.sv
hdl/axi_data_downsize.sv
tb/tb_axi_data_downsize.sv

//--- run.sh
#!/bin/sh
# Build and run the downsizer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f \
  --top-module tb_axi_data_downsize -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
grep -q "SIMULATION PASSED" sim.log
